//--- rtl/rv_m_isa_pkg.sv
package rv_m_isa_pkg;

    // funct3 field of the OP opcode with funct7 = 0000001
    typedef enum logic [2:0] {
        M_MUL    = 3'b000,
        M_MULH   = 3'b001,
        M_MULHSU = 3'b010,
        M_MULHU  = 3'b011,
        M_DIV    = 3'b100,
        M_DIVU   = 3'b101,
        M_REM    = 3'b110,
        M_REMU   = 3'b111
    } m_funct_e;

    typedef struct packed {
        logic is_div;
        logic op_a_signed;
        logic op_b_signed;
        logic want_high;    // upper word of the product
        logic want_rem;     // remainder instead of quotient
    } m_ctrl_t;

endpackage

//--- rtl/muldiv_data_pkg.sv
package muldiv_data_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;

    // iteration count, has to reach XLEN itself
    typedef logic [$clog2(XLEN+1)-1:0] div_count_t;

    typedef struct packed {
        xlen_t quotient;
        xlen_t remainder;
    } div_result_t;

endpackage

//--- rtl/multiplier_pipe.sv
`timescale 1ns/1ps

module multiplier_pipe (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   req_i,
    input  rv_m_isa_pkg::m_ctrl_t  ctrl_i,
    input  muldiv_data_pkg::xlen_t op_a_i,
    input  muldiv_data_pkg::xlen_t op_b_i,
    output muldiv_data_pkg::xlen_t product_o,
    output logic                   done_o
);
    import muldiv_data_pkg::*;

    // operands widened by one bit so every variant is a signed multiply
    typedef struct packed {
        logic            want_high;
        logic [XLEN:0]   op_a;
        logic [XLEN:0]   op_b;
    } mul_stage_t;

    mul_stage_t                s1_q;
    logic                      s1_valid_q;
    logic signed [2*XLEN+1:0]  prod_full;
    xlen_t                     product_q;
    logic                      done_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_valid_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            s1_valid_q <= req_i;
            done_q     <= s1_valid_q;
        end
    end

    // stage 1: sign or zero extension
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            s1_q.want_high <= ctrl_i.want_high;
            s1_q.op_a      <= {ctrl_i.op_a_signed & op_a_i[XLEN-1], op_a_i};
            s1_q.op_b      <= {ctrl_i.op_b_signed & op_b_i[XLEN-1], op_b_i};
        end
    end

    assign prod_full = $signed(s1_q.op_a) * $signed(s1_q.op_b);

    // stage 2: full product, keep one word
    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            if (s1_q.want_high) begin
                product_q <= prod_full[2*XLEN-1:XLEN];
            end else begin
                product_q <= prod_full[XLEN-1:0];
            end
        end
    end

    assign product_o = product_q;
    assign done_o    = done_q;

endmodule

//--- rtl/divider_nonrestoring.sv
`timescale 1ns/1ps

module divider_nonrestoring #(
    parameter muldiv_data_pkg::div_count_t DIV_STEPS = 32
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         req_i,
    input  logic                         signed_i,
    input  muldiv_data_pkg::xlen_t       dividend_i,
    input  muldiv_data_pkg::xlen_t       divisor_i,
    output muldiv_data_pkg::div_result_t result_o,
    output logic                         done_o
);
    import muldiv_data_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ITERATE,
        S_CORRECT,
        S_SIGN_FIX
    } div_state_e;

    localparam xlen_t MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    div_state_e     state_q;
    div_count_t     cnt_q;
    logic [XLEN:0]  acc_q;      // partial remainder with its sign in the msb
    xlen_t          quo_q;      // dividend bits shift out as quotient bits shift in
    xlen_t          dvs_q;
    logic           quo_neg_q;
    logic           rem_neg_q;

    logic           div_zero;
    logic           overflow;
    logic           dvd_neg;
    logic           dvs_neg;
    xlen_t          dvd_mag;
    xlen_t          dvs_mag;
    logic [XLEN:0]  acc_shift;
    logic [XLEN:0]  acc_step;

    assign div_zero = (divisor_i == '0);
    assign overflow = signed_i && (dividend_i == MOST_NEG) && (divisor_i == '1);

    // unsigned operands are taken as they are
    assign dvd_neg = signed_i & dividend_i[XLEN-1];
    assign dvs_neg = signed_i & divisor_i[XLEN-1];
    assign dvd_mag = dvd_neg ? ~dividend_i + 1'b1 : dividend_i;
    assign dvs_mag = dvs_neg ? ~divisor_i + 1'b1 : divisor_i;

    // shift in the next dividend bit then add or subtract by the old sign
    assign acc_shift = {acc_q[XLEN-1:0], quo_q[XLEN-1]};
    assign acc_step  = acc_q[XLEN] ? acc_shift + {1'b0, dvs_q}
                                   : acc_shift - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_i) begin
                        cnt_q <= DIV_STEPS;
                        if (div_zero || overflow) begin
                            state_q <= S_SIGN_FIX;  // result already final
                        end else begin
                            state_q <= S_ITERATE;
                        end
                    end
                end
                S_ITERATE: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == div_count_t'(1)) begin
                        state_q <= S_CORRECT;
                    end
                end
                S_CORRECT: begin
                    state_q <= S_SIGN_FIX;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            S_IDLE: begin
                if (req_i) begin
                    if (div_zero) begin
                        quo_q     <= '1;
                        acc_q     <= {1'b0, dividend_i};
                        quo_neg_q <= 1'b0;
                        rem_neg_q <= 1'b0;
                    end else if (overflow) begin
                        quo_q     <= dividend_i;
                        acc_q     <= '0;
                        quo_neg_q <= 1'b0;
                        rem_neg_q <= 1'b0;
                    end else begin
                        quo_q     <= dvd_mag;
                        dvs_q     <= dvs_mag;
                        acc_q     <= '0;
                        quo_neg_q <= dvd_neg ^ dvs_neg;
                        rem_neg_q <= dvd_neg;   // remainder follows the dividend
                    end
                end
            end
            S_ITERATE: begin
                acc_q <= acc_step;
                quo_q <= {quo_q[XLEN-2:0], ~acc_step[XLEN]};
            end
            S_CORRECT: begin
                if (acc_q[XLEN]) begin
                    acc_q <= acc_q + {1'b0, dvs_q};
                end
            end
            default: begin
            end
        endcase
    end

    // sign fix is applied on the way out during the done cycle
    always_comb begin
        result_o.quotient  = quo_neg_q ? ~quo_q + 1'b1 : quo_q;
        result_o.remainder = rem_neg_q ? ~acc_q[XLEN-1:0] + 1'b1 : acc_q[XLEN-1:0];
    end

    assign done_o = (state_q == S_SIGN_FIX);

    a_req_only_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_i |-> state_q == S_IDLE);

endmodule

//--- rtl/m_unit_top.sv
`timescale 1ns/1ps

module m_unit_top #(
    parameter muldiv_data_pkg::div_count_t DIV_STEPS = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   req_i,
    input  rv_m_isa_pkg::m_funct_e op_i,
    input  muldiv_data_pkg::xlen_t rs1_i,
    input  muldiv_data_pkg::xlen_t rs2_i,
    output muldiv_data_pkg::xlen_t result_o,
    output logic                   done_o,
    output logic                   busy_o
);
    import rv_m_isa_pkg::*;
    import muldiv_data_pkg::*;

    m_ctrl_t      ctrl;
    logic         mul_req;
    logic         div_req;
    xlen_t        mul_product;
    logic         mul_done;
    div_result_t  div_result;
    logic         div_done;
    logic         busy_q;
    logic         want_rem_q;
    xlen_t        result_q;

    always_comb begin
        ctrl = '0;
        case (op_i)
            M_MUL: begin
                ctrl.op_a_signed = 1'b1;
                ctrl.op_b_signed = 1'b1;
            end
            M_MULH: begin
                ctrl.op_a_signed = 1'b1;
                ctrl.op_b_signed = 1'b1;
                ctrl.want_high   = 1'b1;
            end
            M_MULHSU: begin
                ctrl.op_a_signed = 1'b1;
                ctrl.want_high   = 1'b1;
            end
            M_MULHU: begin
                ctrl.want_high = 1'b1;
            end
            M_DIV: begin
                ctrl.is_div      = 1'b1;
                ctrl.op_a_signed = 1'b1;
                ctrl.op_b_signed = 1'b1;
            end
            M_DIVU: begin
                ctrl.is_div = 1'b1;
            end
            M_REM: begin
                ctrl.is_div      = 1'b1;
                ctrl.op_a_signed = 1'b1;
                ctrl.op_b_signed = 1'b1;
                ctrl.want_rem    = 1'b1;
            end
            default: begin  // M_REMU
                ctrl.is_div   = 1'b1;
                ctrl.want_rem = 1'b1;
            end
        endcase
    end

    assign mul_req = req_i & ~ctrl.is_div;
    assign div_req = req_i & ctrl.is_div;

    multiplier_pipe i_mul (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (mul_req),
        .ctrl_i    (ctrl),
        .op_a_i    (rs1_i),
        .op_b_i    (rs2_i),
        .product_o (mul_product),
        .done_o    (mul_done)
    );

    divider_nonrestoring #(
        .DIV_STEPS (DIV_STEPS)
    ) i_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (div_req),
        .signed_i   (ctrl.op_a_signed),
        .dividend_i (rs1_i),
        .divisor_i  (rs2_i),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    // busy covers the division up to its done cycle, multiplies never set it
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q <= 1'b0;
        end else if (div_req) begin
            busy_q <= 1'b1;
        end else if (div_done) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (div_req) begin
            want_rem_q <= ctrl.want_rem;
        end
        if (done_o) begin
            result_q <= result_o;   // held between pulses
        end
    end

    always_comb begin
        if (mul_done) begin
            result_o = mul_product;
        end else if (div_done) begin
            result_o = want_rem_q ? div_result.remainder : div_result.quotient;
        end else begin
            result_o = result_q;
        end
    end

    assign done_o = mul_done | div_done;
    assign busy_o = busy_q;

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_i |-> !busy_o);

    // a div special case strobed right after a mul issue lands on the mul's done cycle
    a_done_apart: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(mul_done && div_done));

endmodule

//--- bench/m_unit_ref.svh
`ifndef M_UNIT_REF_SVH
`define M_UNIT_REF_SVH

localparam logic [31:0] LCG_SEED = 32'd41;

logic [31:0] lcg_state = LCG_SEED;

// 32-bit lcg, upper bits folded down to improve the low bits
function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
endfunction

// expected RV32M result straight from the ISA definition
function automatic xlen_t m_ref(input m_funct_e op, input xlen_t a, input xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic        [63:0] ua;
    logic        [63:0] ub;
    logic signed [63:0] sprod;
    logic        [63:0] uprod;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic               ovf;

    sa    = {{32{a[31]}}, a};
    sb    = {{32{b[31]}}, b};
    ua    = {32'h0, a};
    ub    = {32'h0, b};
    sa32  = a;
    sb32  = b;
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        M_MUL: begin
            uprod = ua * ub;
            return uprod[31:0];
        end
        M_MULH: begin
            sprod = sa * sb;
            return sprod[63:32];
        end
        M_MULHSU: begin
            sprod = sa * $signed(ub);   // ub is zero extended, stays positive
            return sprod[63:32];
        end
        M_MULHU: begin
            uprod = ua * ub;
            return uprod[63:32];
        end
        M_DIV: begin
            if (b == 32'h0) return 32'hffff_ffff;
            if (ovf) return a;
            return sa32 / sb32;     // truncates toward zero
        end
        M_DIVU: begin
            if (b == 32'h0) return 32'hffff_ffff;
            return a / b;
        end
        M_REM: begin
            if (b == 32'h0) return a;
            if (ovf) return 32'h0;
            return sa32 % sb32;     // sign of the dividend
        end
        default: begin
            if (b == 32'h0) return a;
            return a % b;
        end
    endcase
endfunction

`endif

//--- bench/m_unit_tb.sv
`timescale 1ns/1ps

module m_unit_tb;
    import rv_m_isa_pkg::*;
    import muldiv_data_pkg::*;

    `include "m_unit_ref.svh"

    localparam int N_MUL_RAND = 200;
    localparam int N_DIV_RAND = 100;
    localparam int N_DIV_ZERO = 12;
    localparam int N_OVF      = 2;
    localparam int N_CORNER   = 200;    // half multiplies, half divisions
    localparam int MAX_CYCLES = 16 + 20 + (N_MUL_RAND + N_CORNER / 2) * 3
                              + (N_DIV_RAND + N_DIV_ZERO + N_OVF + N_CORNER / 2) * 36 + 400;

    typedef struct packed {
        m_funct_e    op;
        xlen_t       a;
        xlen_t       b;
        xlen_t       value;
        logic        is_div;
        logic [31:0] req_cycle;
        logic [31:0] due_cycle;
    } exp_entry_t;

    logic       clk_i;
    logic       rst_i;
    logic       req_i;
    m_funct_e   op_i;
    xlen_t      rs1_i;
    xlen_t      rs2_i;
    xlen_t      result_o;
    logic       done_o;
    logic       busy_o;

    exp_entry_t exp_q[$];
    int         cycle_cnt = 0;
    int         chk_cnt = 0;
    int         err_cnt = 0;

    m_funct_e   mul_ops[4] = '{M_MUL, M_MULH, M_MULHSU, M_MULHU};
    m_funct_e   div_ops[4] = '{M_DIV, M_DIVU, M_REM, M_REMU};
    xlen_t      corner_vals[5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    m_unit_top #(
        .DIV_STEPS (div_count_t'(XLEN))
    ) i_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .result_o (result_o),
        .done_o   (done_o),
        .busy_o   (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        while (cycle_cnt < MAX_CYCLES) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic advance();
        @(posedge clk_i);
        #2;
    endtask

    // divisions wait for the multiplier to drain so done pulses never meet
    task automatic issue(input m_funct_e op, input xlen_t a, input xlen_t b);
        exp_entry_t e;
        int         lat;
        e.is_div = op inside {M_DIV, M_DIVU, M_REM, M_REMU};
        if (!e.is_div) begin
            lat = 2;
        end else if (b == 32'h0) begin
            lat = 1;
        end else if ((op == M_DIV || op == M_REM) && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            lat = 1;
        end else begin
            lat = XLEN + 2;
        end
        while (busy_o || (e.is_div && exp_q.size() != 0)) advance();
        e.op        = op;
        e.a         = a;
        e.b         = b;
        e.value     = m_ref(op, a, b);
        e.req_cycle = cycle_cnt + 1;    // sampled at the next edge
        e.due_cycle = cycle_cnt + 1 + lat;
        exp_q.push_back(e);
        req_i = 1'b1;
        op_i  = op;
        rs1_i = a;
        rs2_i = b;
        advance();
        req_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || busy_o) advance();
    endtask

    task automatic report_test(input int num, input string name, input int ops,
                               input int errs_before);
        $display("test %0d %-14s %4d ops  %0d errors", num, name, ops, err_cnt - errs_before);
    endtask

    always @(negedge clk_i) begin : compare
        exp_entry_t e;
        if (rst_i) begin
            if (exp_q.size() != 0 && exp_q[0].is_div && cycle_cnt >= int'(exp_q[0].req_cycle)) begin
                check(32'(busy_o), 32'h1, "busy_o during division");
            end
            if (done_o) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("done_o pulsed at %0t with no request outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check(result_o, e.value,
                          $sformatf("result of %s %h %h", e.op.name(), e.a, e.b));
                    check(cycle_cnt + 1, e.due_cycle,
                          $sformatf("done cycle of %s %h %h", e.op.name(), e.a, e.b));
                end
            end
        end
    end

    initial begin : stimulus
        int    errs_before;
        int    idx;
        xlen_t a;
        xlen_t b;
        rst_i = 1'b0;
        req_i = 1'b0;
        op_i  = M_MUL;
        rs1_i = '0;
        rs2_i = '0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b1;

        errs_before = err_cnt;
        repeat (20) begin
            advance();
            check(32'(done_o), 32'h0, "done_o while idle");
            check(32'(busy_o), 32'h0, "busy_o while idle");
        end
        report_test(1, "idle", 0, errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < N_MUL_RAND; i++) begin
            idx = rand_word() % 4;
            a   = rand_word();
            b   = rand_word();
            issue(mul_ops[idx], a, b);
        end
        drain();
        report_test(2, "mul_random", N_MUL_RAND, errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < N_DIV_RAND; i++) begin
            idx = rand_word() % 4;
            a   = rand_word();
            b   = rand_word();
            case (i % 4)
                1: b = b >> (rand_word() % 31);
                2: b = {1'b1, b[30:0]};
                3: begin
                    a = {1'b1, a[30:0]};
                    b = b >> (rand_word() % 16);
                end
                default: ;
            endcase
            if (b == 32'h0) b = 32'd3;  // zero divisor has its own test
            issue(div_ops[idx], a, b);
        end
        drain();
        report_test(3, "div_random", N_DIV_RAND, errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < 4; i++) begin
            issue(div_ops[i], 32'h1234_5678, 32'h0);
            issue(div_ops[i], 32'h8000_0000, 32'h0);
            issue(div_ops[i], rand_word(), 32'h0);
        end
        drain();
        report_test(4, "div_by_zero", N_DIV_ZERO, errs_before);

        errs_before = err_cnt;
        issue(M_DIV, 32'h8000_0000, 32'hffff_ffff);
        issue(M_REM, 32'h8000_0000, 32'hffff_ffff);
        drain();
        report_test(5, "overflow", N_OVF, errs_before);

        // op loop innermost so each MUL follows a REMU done pulse
        errs_before = err_cnt;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int k = 0; k < 8; k++) begin
                    issue(m_funct_e'(k), corner_vals[i], corner_vals[j]);
                end
            end
        end
        drain();
        report_test(6, "corners", N_CORNER, errs_before);

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- m_unit_top.f
+incdir+bench
rtl/rv_m_isa_pkg.sv
rtl/muldiv_data_pkg.sv
rtl/multiplier_pipe.sv
rtl/divider_nonrestoring.sv
rtl/m_unit_top.sv
bench/m_unit_tb.sv

//--- Makefile
TOP = m_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f m_unit_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
